/* Makefile */
# Verilator build and run of the SDRAM controller testbench

OBJ := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run tb_hpdmc"
	@echo "  clean  remove build products"
	@echo "  help   show this list"

test:
	verilator --binary --assert -Wno-fatal -f vlog.f --top-module tb_hpdmc -Mdir $(OBJ)
	@out="$$(./$(OBJ)/Vtb_hpdmc)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf $(OBJ)

/* common/hpdmc_config.svh */
// Device geometry, pad widths, timing register reset values and burst constants
`ifndef HPDMC_CONFIG_SVH
`define HPDMC_CONFIG_SVH

// -------------------------------------------------------------------------
// Geometry of the single 16-bit SDR device
// -------------------------------------------------------------------------

// Byte address width of the array
`define SDRAM_DEPTH 23
// Column address bits
`define SDRAM_COLDEPTH 8
// Word address less column bits and the two bank bits
`define SDRAM_ROWDEPTH (`SDRAM_DEPTH - 1 - `SDRAM_COLDEPTH - 2)

// Data and mask pad widths
`define DQ_WIDTH 16
`define DQM_WIDTH 2

// -------------------------------------------------------------------------
// Timing register reset values, in sys_clk cycles
// -------------------------------------------------------------------------

`define TIM_RP_RST 3'd2
`define TIM_RCD_RST 3'd2
// CAS latency select, 0 means CL2
`define TIM_CAS_RST 1'b0
`define TIM_RFC_RST 4'd8
`define TIM_WR_RST 2'd2
`define TIM_REFI_RST 11'd740

// Bank busy time after a read burst
`define READ_BURST_HOLD 4'd8
// Cycles the controller drives DQ for one write burst
`define WRITE_DRIVE_CYCLES 4'd9

`endif

/* common/hpdmc_pkg.sv */
// Shared types: SDRAM command word and opcodes, timing fields, word address, FSM states
`default_nettype none

`include "hpdmc_config.svh"

package hpdmc_pkg;

	// Command word as registered onto the SDRAM pins
	typedef struct packed {
		logic cs_n;
		logic ras_n;
		logic cas_n;
		logic we_n;
		logic [`SDRAM_ROWDEPTH-1:0] adr;
		logic [1:0] ba;
	} sdram_cmd_t;

	// Opcodes as {cs_n, ras_n, cas_n, we_n}
	typedef enum logic [3:0] {
		CMD_NOP = 4'b1111,
		CMD_ACT = 4'b0011,
		CMD_READ = 4'b0101,
		CMD_WRITE = 4'b0100,
		CMD_PRE = 4'b0010,
		CMD_REF = 4'b0001
	} sdram_op_e;

	// Programmable timing, all in sys_clk cycles except cas
	typedef struct packed {
		logic [2:0] rp;
		logic [2:0] rcd;
		logic cas;
		logic [3:0] rfc;
		logic [1:0] wr;
		logic [10:0] refi;
	} tim_t;

	// Word address split, row on top and column at the bottom
	typedef struct packed {
		logic [`SDRAM_ROWDEPTH-1:0] row;
		logic [1:0] bank;
		logic [`SDRAM_COLDEPTH-1:0] col;
	} word_addr_s;

	// Same word seen flat or split into row, bank and column
	typedef union packed {
		logic [`SDRAM_DEPTH-2:0] flat;
		word_addr_s split;
	} word_addr_u;

	// Management FSM states
	typedef enum logic [2:0] {
		IDLE,
		ACTIVATE,
		READ,
		WRITE,
		PRECHARGEALL,
		AUTOREFRESH,
		AUTOREFRESH_WAIT
	} mgmt_state_e;

endpackage

`default_nettype wire

/* datactl/hpdmc_banktimer.sv */
// Per-bank hold counter that blocks a precharge after a read or write burst
`default_nettype none

`include "hpdmc_config.svh"

module hpdmc_banktimer (
	input logic sys_clk,
	input logic sdram_rst,
	input logic [1:0] tim_wr,
	input logic read,
	input logic write,
	output logic precharge_safe
);

	logic [3:0] counter;

	always_ff @(posedge sys_clk) begin
		if (sdram_rst) begin
			counter <= '0;
			precharge_safe <= 1'b1;
		end else if (read) begin
			// Precharge may cut the burst only after its last word
			counter <= `READ_BURST_HOLD;
			precharge_safe <= 1'b0;
		end else if (write) begin
			// Burst plus write recovery, 8 + tWR
			counter <= {2'b10, tim_wr};
			precharge_safe <= 1'b0;
		end else begin
			if (counter == 4'd1)
				precharge_safe <= 1'b1;
			if (!precharge_safe)
				counter <= counter - 4'd1;
		end
	end

endmodule

`default_nettype wire

/* datactl/hpdmc_datactl.sv */
// Data path timing: read/write safe windows, bank timers, ack, direction and DQ pads
`default_nettype none

`include "hpdmc_config.svh"

module hpdmc_datactl (
	input logic sys_clk,
	input logic sdram_rst,
	input hpdmc_pkg::tim_t tim,
	input logic read,
	input logic write,
	input logic [3:0] concerned_bank,
	input logic [`DQM_WIDTH-1:0] fml_sel,
	input logic [`DQ_WIDTH-1:0] fml_di,
	output logic read_safe,
	output logic write_safe,
	output logic [3:0] precharge_safe,
	output logic data_ack,
	output logic [`DQ_WIDTH-1:0] fml_do,
	output logic [`DQM_WIDTH-1:0] sdram_dqm,
	inout wire [`DQ_WIDTH-1:0] sdram_dq
);

	logic [2:0] rd_cnt;
	logic [3:0] wr_cnt;
	logic [4:0] rd_pipe;
	logic [3:0] dir_cnt;
	logic direction;

	// -------------------------------------------------------------------------
	// Safe windows for the next READ or WRITE command
	// -------------------------------------------------------------------------

	// Turnaround loads shrink by one at CL3 (tim.cas high)
	always_ff @(posedge sys_clk) begin
		if (sdram_rst) begin
			rd_cnt <= '0;
			wr_cnt <= '0;
			read_safe <= 1'b1;
			write_safe <= 1'b1;
		end else if (read) begin
			rd_cnt <= 3'd7;
			wr_cnt <= {3'b100, ~tim.cas};
			read_safe <= 1'b0;
			write_safe <= 1'b0;
		end else if (write) begin
			rd_cnt <= {2'b11, ~tim.cas};
			wr_cnt <= 4'd7;
			read_safe <= 1'b0;
			write_safe <= 1'b0;
		end else begin
			if (rd_cnt == 3'd1)
				read_safe <= 1'b1;
			if (!read_safe)
				rd_cnt <= rd_cnt - 3'd1;
			if (wr_cnt == 4'd1)
				write_safe <= 1'b1;
			if (!write_safe)
				wr_cnt <= wr_cnt - 4'd1;
		end
	end

	// -------------------------------------------------------------------------
	// Ack and write drive
	// -------------------------------------------------------------------------

	// Read ack CL+3 after the read pulse, tap picked by CL
	always_ff @(posedge sys_clk) begin
		if (sdram_rst) begin
			rd_pipe <= '0;
			data_ack <= 1'b0;
		end else begin
			rd_pipe <= {rd_pipe[3:0], read};
			data_ack <= write | (tim.cas ? rd_pipe[4] : rd_pipe[3]);
		end
	end

	// Drive DQ from the cycle the WRITE reaches the pins
	always_ff @(posedge sys_clk) begin
		if (sdram_rst) begin
			dir_cnt <= '0;
			direction <= 1'b0;
		end else if (write) begin
			dir_cnt <= `WRITE_DRIVE_CYCLES;
			direction <= 1'b1;
		end else begin
			if (dir_cnt == 4'd1)
				direction <= 1'b0;
			if (direction)
				dir_cnt <= dir_cnt - 4'd1;
		end
	end

	// Pads, DQM is the inverse of the byte selects
	assign sdram_dq = direction ? fml_di : {`DQ_WIDTH{1'bz}};
	assign sdram_dqm = ~fml_sel;

	always_ff @(posedge sys_clk) begin
		fml_do <= sdram_dq;
	end

	// One precharge hold per bank
	for (genvar i = 0; i < 4; i++) begin : g_bank
		hpdmc_banktimer i_banktimer (
			.sys_clk(sys_clk),
			.sdram_rst(sdram_rst),
			.tim_wr(tim.wr),
			.read(read & concerned_bank[i]),
			.write(write & concerned_bank[i]),
			.precharge_safe(precharge_safe[i])
		);
	end

endmodule

`default_nettype wire

/* logic/hpdmc.sv */
// SDRAM controller top: control registers, management FSM and data path
`default_nettype none

`include "hpdmc_config.svh"

module hpdmc (
	input logic sys_clk,
	input logic sys_rst,

	// Control and status registers
	input logic [1:0] csr_a,
	input logic csr_we,
	input logic [15:0] csr_di,
	output logic [15:0] csr_do,

	// Memory bus, 16-bit words
	input logic [`SDRAM_DEPTH-2:0] fml_adr,
	input logic fml_stb,
	input logic fml_we,
	input logic [`DQM_WIDTH-1:0] fml_sel,
	input logic [`DQ_WIDTH-1:0] fml_di,
	output logic [`DQ_WIDTH-1:0] fml_do,
	output logic fml_ack,

	// SDRAM pins, clock comes from outside in phase with sys_clk
	output logic sdram_cke,
	output hpdmc_pkg::sdram_cmd_t sdram_cmd,
	output logic [`DQM_WIDTH-1:0] sdram_dqm,
	inout wire [`DQ_WIDTH-1:0] sdram_dq
);
	import hpdmc_pkg::*;

	// Software controlled reset and timing
	tim_t tim;
	logic sdram_rst;

	// Column command pulses and target bank
	logic read;
	logic write;
	logic [3:0] concerned_bank;

	// Data path feedback to the FSM
	logic read_safe;
	logic write_safe;
	logic [3:0] precharge_safe;

	hpdmc_ctlif i_ctlif (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.csr_a(csr_a),
		.csr_we(csr_we),
		.csr_di(csr_di),
		.csr_do(csr_do),
		.sdram_rst(sdram_rst),
		.sdram_cke(sdram_cke),
		.tim(tim)
	);

	// Bus ack is the data path ack, fed back to release the front end
	hpdmc_mgmt i_mgmt (
		.sys_clk(sys_clk),
		.sdram_rst(sdram_rst),
		.tim(tim),
		.fml_adr(fml_adr),
		.fml_stb(fml_stb),
		.fml_we(fml_we),
		.data_ack(fml_ack),
		.read_safe(read_safe),
		.write_safe(write_safe),
		.precharge_safe(precharge_safe),
		.read(read),
		.write(write),
		.concerned_bank(concerned_bank),
		.sdram_cmd(sdram_cmd)
	);

	hpdmc_datactl i_datactl (
		.sys_clk(sys_clk),
		.sdram_rst(sdram_rst),
		.tim(tim),
		.read(read),
		.write(write),
		.concerned_bank(concerned_bank),
		.fml_sel(fml_sel),
		.fml_di(fml_di),
		.read_safe(read_safe),
		.write_safe(write_safe),
		.precharge_safe(precharge_safe),
		.data_ack(fml_ack),
		.fml_do(fml_do),
		.sdram_dqm(sdram_dqm),
		.sdram_dq(sdram_dq)
	);

endmodule

`default_nettype wire

/* logic/hpdmc_ctlif.sv */
// Control and status registers: SDRAM reset, CKE and the timing fields
`default_nettype none

`include "hpdmc_config.svh"

module hpdmc_ctlif (
	input logic sys_clk,
	input logic sys_rst,
	input logic [1:0] csr_a,
	input logic csr_we,
	input logic [15:0] csr_di,
	output logic [15:0] csr_do,
	output logic sdram_rst,
	output logic sdram_cke,
	output hpdmc_pkg::tim_t tim
);

	// Register map
	// 0: bit 1 sdram_rst, bit 2 cke
	// 1: reserved, reads zero
	// 2: rp, rcd, cas, rfc, wr from bit 0 up
	// 3: refi
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			csr_do <= '0;
			// Hold the SDRAM side in reset with the clock disabled
			sdram_rst <= 1'b1;
			sdram_cke <= 1'b0;
			tim.rp <= `TIM_RP_RST;
			tim.rcd <= `TIM_RCD_RST;
			tim.cas <= `TIM_CAS_RST;
			tim.rfc <= `TIM_RFC_RST;
			tim.wr <= `TIM_WR_RST;
			tim.refi <= `TIM_REFI_RST;
		end else begin
			if (csr_we) begin
				case (csr_a)
					2'd0: begin
						sdram_rst <= csr_di[1];
						sdram_cke <= csr_di[2];
					end
					2'd2: begin
						tim.rp <= csr_di[2:0];
						tim.rcd <= csr_di[5:3];
						tim.cas <= csr_di[6];
						tim.rfc <= csr_di[10:7];
						tim.wr <= csr_di[12:11];
					end
					2'd3: begin
						tim.refi <= csr_di[10:0];
					end
					default: begin
					end
				endcase
			end

			// Registered readback, shows the value before a same-cycle write
			case (csr_a)
				2'd0: csr_do <= {13'd0, sdram_cke, sdram_rst, 1'b0};
				2'd2: csr_do <= {3'd0, tim.wr, tim.rfc, tim.cas, tim.rcd, tim.rp};
				2'd3: csr_do <= {5'd0, tim.refi};
				default: csr_do <= '0;
			endcase
		end
	end

	// Precharge and activate waits in the FSM count down from these
	a_tim_nonzero: assert property (@(posedge sys_clk) disable iff (sys_rst)
		csr_we && csr_a == 2'd2 |=> tim.rp != 3'd0 && tim.rcd != 3'd0);

endmodule

`default_nettype wire

/* mgmt/hpdmc_mgmt.sv */
// Bus front end, open-row tracking, timing counters and the SDRAM command FSM
`default_nettype none

`include "hpdmc_config.svh"

module hpdmc_mgmt (
	input logic sys_clk,
	input logic sdram_rst,
	input hpdmc_pkg::tim_t tim,
	input logic [`SDRAM_DEPTH-2:0] fml_adr,
	input logic fml_stb,
	input logic fml_we,
	input logic data_ack,
	input logic read_safe,
	input logic write_safe,
	input logic [3:0] precharge_safe,
	output logic read,
	output logic write,
	output logic [3:0] concerned_bank,
	output hpdmc_pkg::sdram_cmd_t sdram_cmd
);
	import hpdmc_pkg::*;

	logic stb_en;
	logic stb;
	word_addr_u addr;

	logic [3:0] has_openrow;
	logic [`SDRAM_ROWDEPTH-1:0] openrows [4];
	logic [3:0] track_open;
	logic [3:0] track_close;
	logic bank_open;
	logic page_hit;
	logic col_safe;

	logic [2:0] rp_cnt;
	logic [2:0] rcd_cnt;
	logic [3:0] rfc_cnt;
	logic [10:0] refi_cnt;
	logic load_rp;
	logic load_rcd;
	logic load_rfc;
	logic load_refi;
	logic rp_done;
	logic rcd_done;
	logic rfc_done;
	logic must_refresh;

	mgmt_state_e state;
	mgmt_state_e next_state;
	sdram_op_e op;
	logic [`SDRAM_ROWDEPTH-1:0] adr_next;
	logic do_act;
	logic do_col;

	// -------------------------------------------------------------------------
	// Bus front end
	// -------------------------------------------------------------------------

	// Mask the strobe from column command until its data ack
	always_ff @(posedge sys_clk) begin
		if (sdram_rst) begin
			stb_en <= 1'b1;
		end else if (data_ack) begin
			stb_en <= 1'b1;
		end else if (read || write) begin
			stb_en <= 1'b0;
		end
	end

	assign stb = fml_stb & stb_en;
	// Byte address to word address with the byte select bit 0 dropped
	assign addr.flat = {1'b0, fml_adr[`SDRAM_DEPTH-2:1]};

	// -------------------------------------------------------------------------
	// Open-row tracking
	// -------------------------------------------------------------------------

	assign concerned_bank = 4'b0001 << addr.split.bank;
	assign bank_open = has_openrow[addr.split.bank];
	assign page_hit = bank_open && openrows[addr.split.bank] == addr.split.row;
	assign col_safe = fml_we ? write_safe : read_safe;

	always_ff @(posedge sys_clk) begin
		if (sdram_rst)
			has_openrow <= '0;
		else
			has_openrow <= (has_openrow | track_open) & ~track_close;
	end

	always_ff @(posedge sys_clk) begin
		for (int i = 0; i < 4; i++) begin
			if (track_open[i])
				openrows[i] <= addr.split.row;
		end
	end

	// -------------------------------------------------------------------------
	// Timing counters that reload on their command and stop at zero
	// -------------------------------------------------------------------------

	assign rp_done = rp_cnt == 3'd0;
	assign rcd_done = rcd_cnt == 3'd0;
	assign rfc_done = rfc_cnt == 4'd0;
	// Counter starts at zero so refresh is due first
	assign must_refresh = refi_cnt == 11'd0;

	always_ff @(posedge sys_clk) begin
		if (sdram_rst) begin
			rp_cnt <= '0;
			rcd_cnt <= '0;
			rfc_cnt <= '0;
			refi_cnt <= '0;
		end else begin
			if (load_rp)
				rp_cnt <= tim.rp;
			else if (!rp_done)
				rp_cnt <= rp_cnt - 3'd1;
			if (load_rcd)
				rcd_cnt <= tim.rcd;
			else if (!rcd_done)
				rcd_cnt <= rcd_cnt - 3'd1;
			if (load_rfc)
				rfc_cnt <= tim.rfc;
			else if (!rfc_done)
				rfc_cnt <= rfc_cnt - 4'd1;
			if (load_refi)
				refi_cnt <= tim.refi;
			else if (!must_refresh)
				refi_cnt <= refi_cnt - 11'd1;
		end
	end

	// -------------------------------------------------------------------------
	// Command FSM
	// -------------------------------------------------------------------------

	always_comb begin
		next_state = state;
		op = CMD_NOP;
		adr_next = '0;
		load_rp = 1'b0;
		load_rcd = 1'b0;
		load_rfc = 1'b0;
		load_refi = 1'b0;
		track_open = '0;
		track_close = '0;
		do_act = 1'b0;
		do_col = 1'b0;
		read = 1'b0;
		write = 1'b0;

		case (state)
			IDLE: begin
				if (must_refresh) begin
					next_state = PRECHARGEALL;
				end else if (stb) begin
					if (page_hit) begin
						do_col = col_safe;
					end else if (bank_open) begin
						// Row miss closes the bank once its burst is over
						if (precharge_safe[addr.split.bank]) begin
							op = CMD_PRE;
							track_close = concerned_bank;
							load_rp = 1'b1;
							next_state = ACTIVATE;
						end
					end else begin
						do_act = 1'b1;
					end
				end
			end
			ACTIVATE: begin
				do_act = rp_done;
			end
			READ, WRITE: begin
				do_col = rcd_done && col_safe;
			end
			PRECHARGEALL: begin
				// A10 high closes all banks once every burst is over
				if (&precharge_safe) begin
					op = CMD_PRE;
					adr_next[10] = 1'b1;
					track_close = 4'b1111;
					load_rp = 1'b1;
					next_state = AUTOREFRESH;
				end
			end
			AUTOREFRESH: begin
				if (rp_done) begin
					op = CMD_REF;
					load_refi = 1'b1;
					load_rfc = 1'b1;
					next_state = AUTOREFRESH_WAIT;
				end
			end
			AUTOREFRESH_WAIT: begin
				if (rfc_done)
					next_state = IDLE;
			end
			default: begin
				next_state = IDLE;
			end
		endcase

		// Open the row and pick the column state from the held bus direction
		if (do_act) begin
			op = CMD_ACT;
			adr_next = addr.split.row;
			track_open = concerned_bank;
			load_rcd = 1'b1;
			next_state = fml_we ? WRITE : READ;
		end

		// Column command with A10 low and no auto precharge
		if (do_col) begin
			if (fml_we)
				op = CMD_WRITE;
			else
				op = CMD_READ;
			adr_next[`SDRAM_COLDEPTH-1:0] = addr.split.col;
			read = !fml_we;
			write = fml_we;
			next_state = IDLE;
		end
	end

	// Output register puts the decision on the pins one cycle later
	always_ff @(posedge sys_clk) begin
		if (sdram_rst) begin
			state <= IDLE;
			sdram_cmd <= {CMD_NOP, {`SDRAM_ROWDEPTH{1'b0}}, 2'b00};
		end else begin
			state <= next_state;
			sdram_cmd <= {op, adr_next, addr.split.bank};
		end
	end

	// The front end holds off a second column command in the next cycle
	a_one_col: assert property (@(posedge sys_clk) disable iff (sdram_rst)
		(read || write) |-> !(read && write) ##1 !(read || write));

	// Column commands only reach an open bank
	a_col_open: assert property (@(posedge sys_clk) disable iff (sdram_rst)
		(read || write) |-> has_openrow[addr.split.bank]);

endmodule

`default_nettype wire

/* test/tb_hpdmc_ref.svh */
// Reference model: CSR word encoding, address split into row/bank/column, xorshift
`ifndef TB_HPDMC_REF_SVH
`define TB_HPDMC_REF_SVH

// Register 0, bit 1 is the SDRAM reset and bit 2 is CKE
function automatic logic [15:0] csr_ctrl_word(input logic rst, input logic cke);
	return (16'(cke) << 2) | (16'(rst) << 1);
endfunction

// Register 2, fields packed from bit 0 upward
function automatic logic [15:0] csr_tim_word(input int rp, input int rcd, input int cas,
		input int rfc, input int wr);
	return 16'((rp & 7) | ((rcd & 7) << 3) | ((cas & 1) << 6) | ((rfc & 15) << 7)
		| ((wr & 3) << 11));
endfunction

// Byte address to word address, then column in the low 8 bits
function automatic logic [7:0] ref_col(input logic [21:0] byte_adr);
	return 8'((byte_adr >> 1) & 22'hff);
endfunction

// Bank sits just above the column
function automatic logic [1:0] ref_bank(input logic [21:0] byte_adr);
	return 2'((byte_adr >> 9) & 22'h3);
endfunction

// Row takes everything above the bank
function automatic logic [11:0] ref_row(input logic [21:0] byte_adr);
	return 12'(byte_adr >> 11);
endfunction

// Stimulus generator for the DQ value
function automatic logic [31:0] xorshift(input logic [31:0] s);
	s = s ^ (s << 13);
	s = s ^ (s >> 17);
	s = s ^ (s << 5);
	return s;
endfunction

`endif

/* test/tb_hpdmc.sv */
// SDRAM controller testbench with clock, reset, bus and CSR stimulus, command log and checks
`default_nettype none

`include "hpdmc_config.svh"

module tb_hpdmc;
	import hpdmc_pkg::*;

	`include "tb_hpdmc_ref.svh"

	localparam int MAX_CYCLES = 4000;
	localparam int REFI = 300;
	// CL3 as selected by cas = 1 in the timing word
	localparam int CAS_LAT = 3;

	logic sys_clk;
	logic sys_rst;
	logic [1:0] csr_a;
	logic csr_we;
	logic [15:0] csr_di;
	logic [15:0] csr_do;
	logic [21:0] fml_adr;
	logic fml_stb;
	logic fml_we;
	logic [1:0] fml_sel;
	logic [15:0] fml_di;
	logic [15:0] fml_do;
	logic fml_ack;
	logic sdram_cke;
	sdram_cmd_t sdram_cmd;
	logic [1:0] sdram_dqm;
	wire [15:0] sdram_dq;

	logic [15:0] dq_val;
	logic [3:0] cmd_op;
	logic [3:0] wr_hold;
	logic dq_release;
	logic [31:0] seed;
	int cycle;
	int errors;
	int tests_run;
	int tests_failed;
	int err_mark;

	// Command log filled by the monitor
	logic [3:0] op_q [$];
	logic [11:0] adr_q [$];
	logic [1:0] ba_q [$];
	int cyc_q [$];

	hpdmc i_dut (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.csr_a(csr_a),
		.csr_we(csr_we),
		.csr_di(csr_di),
		.csr_do(csr_do),
		.fml_adr(fml_adr),
		.fml_stb(fml_stb),
		.fml_we(fml_we),
		.fml_sel(fml_sel),
		.fml_di(fml_di),
		.fml_do(fml_do),
		.fml_ack(fml_ack),
		.sdram_cke(sdram_cke),
		.sdram_cmd(sdram_cmd),
		.sdram_dqm(sdram_dqm),
		.sdram_dq(sdram_dq)
	);

	// Opcode bits of the command on the pins
	assign cmd_op = {sdram_cmd.cs_n, sdram_cmd.ras_n, sdram_cmd.cas_n, sdram_cmd.we_n};

	// The SDRAM model lets go of DQ for the write burst that starts with WRITE on the pins
	assign dq_release = cmd_op == CMD_WRITE || wr_hold != 4'd0;
	assign sdram_dq = dq_release ? 16'hzzzz : dq_val;

	always @(posedge sys_clk) begin
		if (cmd_op == CMD_WRITE)
			wr_hold <= `WRITE_DRIVE_CYCLES - 4'd1;
		else if (wr_hold != 4'd0)
			wr_hold <= wr_hold - 4'd1;
	end

	always #5 sys_clk = ~sys_clk;

	// -------------------------------------------------------------------------
	// Watchdog and command monitor
	// -------------------------------------------------------------------------

	always @(posedge sys_clk) begin
		cycle <= cycle + 1;
		if (cycle >= MAX_CYCLES) begin
			$display("Timeout, no result after %0d cycles", MAX_CYCLES);
			$display("Test failed");
			$finish;
		end
	end

	// Sampled mid-cycle after the command register has settled
	always @(negedge sys_clk) begin
		if (cmd_op != CMD_NOP) begin
			op_q.push_back(cmd_op);
			adr_q.push_back(sdram_cmd.adr);
			ba_q.push_back(sdram_cmd.ba);
			cyc_q.push_back(cycle);
		end
	end

	// Write data and masks on the pads while the DUT drives
	always @(negedge sys_clk) begin
		if (dq_release) begin
			if (sdram_dq !== fml_di) begin
				$display("ERR sdram_dq: got %h expected %h", sdram_dq, fml_di);
				errors++;
			end
			if (sdram_dqm !== ~fml_sel) begin
				$display("ERR sdram_dqm: got %h expected %h", sdram_dqm, ~fml_sel);
				errors++;
			end
		end
	end

	// -------------------------------------------------------------------------
	// Stimulus and check helpers
	// -------------------------------------------------------------------------

	task automatic csr_write(input logic [1:0] a, input logic [15:0] d);
		@(negedge sys_clk);
		csr_a = a;
		csr_di = d;
		csr_we = 1'b1;
		@(negedge sys_clk);
		csr_we = 1'b0;
	endtask

	task automatic csr_check(input logic [1:0] a, input logic [15:0] exp);
		@(negedge sys_clk);
		csr_a = a;
		@(negedge sys_clk);
		if (csr_do !== exp) begin
			$display("ERR csr_do[reg %0d]: got %h expected %h", a, csr_do, exp);
			errors++;
		end
	endtask

	// One bus access held until ack with the write data held through the drive window
	task automatic bus_access(input logic we, input logic [21:0] adr, input logic [15:0] d,
			output logic [15:0] rdata, output int ack_cyc);
		@(negedge sys_clk);
		fml_adr = adr;
		fml_we = we;
		fml_sel = 2'b11;
		fml_di = d;
		fml_stb = 1'b1;
		do begin
			@(negedge sys_clk);
		end while (!fml_ack);
		ack_cyc = cycle;
		rdata = fml_do;
		fml_stb = 1'b0;
		repeat (`WRITE_DRIVE_CYCLES) @(negedge sys_clk);
	endtask

	// Pop the next logged command and compare it
	task automatic expect_cmd(input logic [3:0] op, input logic chk_ba, input logic [1:0] ba,
			input logic [11:0] adr, input logic [11:0] mask, output int cyc);
		logic [3:0] got_op;
		logic [11:0] got_adr;
		logic [1:0] got_ba;
		while (op_q.size() == 0)
			@(negedge sys_clk);
		got_op = op_q.pop_front();
		got_adr = adr_q.pop_front();
		got_ba = ba_q.pop_front();
		cyc = cyc_q.pop_front();
		if (got_op !== op) begin
			$display("ERR sdram_cmd.op: got %h expected %h", got_op, op);
			errors++;
		end
		if ((got_adr & mask) !== (adr & mask)) begin
			$display("ERR sdram_cmd.adr: got %h expected %h", got_adr & mask, adr & mask);
			errors++;
		end
		if (chk_ba && got_ba !== ba) begin
			$display("ERR sdram_cmd.ba: got %h expected %h", got_ba, ba);
			errors++;
		end
	endtask

	task automatic expect_no_more_cmd();
		if (op_q.size() != 0) begin
			$display("Unexpected extra SDRAM command, %0d left in the log", op_q.size());
			errors++;
			op_q.delete();
			adr_q.delete();
			ba_q.delete();
			cyc_q.delete();
		end
	endtask

	task automatic close_test(input string name);
		tests_run++;
		if (errors != err_mark)
			tests_failed++;
		$display("test %0d %s: %s", tests_run, name, errors != err_mark ? "FAILED" : "ok");
		err_mark = errors;
	endtask

	// -------------------------------------------------------------------------
	// Test sequence
	// -------------------------------------------------------------------------

	initial begin
		logic [21:0] a;
		logic [15:0] rd;
		int c0;
		int c1;
		int c2;
		int ack_c;
		sys_clk = 1'b0;
		sys_rst = 1'b1;
		csr_a = '0;
		csr_we = 1'b0;
		csr_di = '0;
		fml_adr = '0;
		fml_stb = 1'b0;
		fml_we = 1'b0;
		fml_sel = 2'b11;
		fml_di = '0;
		wr_hold = '0;
		seed = xorshift(32'h5fc7_b552);
		dq_val = seed[15:0];
		cycle = 0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		err_mark = 0;
		repeat (5) @(posedge sys_clk);
		@(negedge sys_clk);
		sys_rst = 1'b0;

		// Reset values and readback of the timing and reserved registers
		if (sdram_cke !== 1'b0) begin
			$display("ERR sdram_cke: got %h expected %h", sdram_cke, 1'b0);
			errors++;
		end
		csr_check(2'd0, csr_ctrl_word(1'b1, 1'b0));
		csr_check(2'd2, csr_tim_word(2, 2, 0, 8, 2));
		csr_check(2'd3, 16'd740);
		csr_write(2'd2, csr_tim_word(3, 2, CAS_LAT - 2, 6, 1));
		csr_write(2'd3, 16'(REFI));
		csr_write(2'd1, 16'hffff);
		csr_check(2'd2, csr_tim_word(3, 2, CAS_LAT - 2, 6, 1));
		csr_check(2'd3, 16'(REFI));
		csr_check(2'd1, 16'h0000);
		close_test("csr registers");

		// Refresh is due as soon as the SDRAM reset is released
		csr_write(2'd0, csr_ctrl_word(1'b0, 1'b1));
		if (sdram_cke !== 1'b1) begin
			$display("ERR sdram_cke: got %h expected %h", sdram_cke, 1'b1);
			errors++;
		end
		expect_cmd(CMD_PRE, 1'b0, 2'd0, 12'h400, 12'h400, c0);
		expect_cmd(CMD_REF, 1'b0, 2'd0, 12'h000, 12'h000, c1);
		expect_cmd(CMD_PRE, 1'b0, 2'd0, 12'h400, 12'h400, c0);
		expect_cmd(CMD_REF, 1'b0, 2'd0, 12'h000, 12'h000, c2);
		if (c2 - c1 < REFI) begin
			$display("Refresh came after %0d cycles, sooner than %0d", c2 - c1, REFI);
			errors++;
		end
		expect_no_more_cmd();
		close_test("refresh");

		// Write to row 5 bank 1 column 0x12 in a closed bank
		a = 22'h02a24;
		bus_access(1'b1, a, 16'ha5c3, rd, ack_c);
		expect_cmd(CMD_ACT, 1'b1, ref_bank(a), ref_row(a), 12'hfff, c0);
		expect_cmd(CMD_WRITE, 1'b1, ref_bank(a), 12'(ref_col(a)), 12'h4ff, c1);
		// Write ack follows the column pulse by one cycle, as the WRITE does on the pins
		if (ack_c != c1) begin
			$display("ERR fml_ack cycle: got %h expected %h", ack_c, c1);
			errors++;
		end
		expect_no_more_cmd();
		close_test("write to closed bank");

		// Other column in the same row
		a = 22'h02a68;
		bus_access(1'b1, a, 16'h3c5a, rd, ack_c);
		expect_cmd(CMD_WRITE, 1'b1, ref_bank(a), 12'(ref_col(a)), 12'h4ff, c0);
		expect_no_more_cmd();
		close_test("page hit");

		// Row 9 in the same bank
		a = 22'h04a40;
		bus_access(1'b1, a, 16'h0ff0, rd, ack_c);
		expect_cmd(CMD_PRE, 1'b1, ref_bank(a), 12'h000, 12'h400, c0);
		expect_cmd(CMD_ACT, 1'b1, ref_bank(a), ref_row(a), 12'hfff, c0);
		expect_cmd(CMD_WRITE, 1'b1, ref_bank(a), 12'(ref_col(a)), 12'h4ff, c0);
		expect_no_more_cmd();
		close_test("row miss");

		// Read back what the SDRAM model drives
		seed = xorshift(seed);
		dq_val = seed[15:0];
		a = 22'h04a42;
		bus_access(1'b0, a, 16'h0000, rd, ack_c);
		expect_cmd(CMD_READ, 1'b1, ref_bank(a), 12'(ref_col(a)), 12'h4ff, c0);
		if (rd !== dq_val) begin
			$display("ERR fml_do: got %h expected %h", rd, dq_val);
			errors++;
		end
		// Read ack is CL+3 after the pulse and so CL+2 after READ on the pins
		if (ack_c - c0 != CAS_LAT + 2) begin
			$display("ERR fml_ack latency: got %h expected %h", ack_c - c0, CAS_LAT + 2);
			errors++;
		end
		expect_no_more_cmd();
		close_test("read");

		$display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+common
+incdir+test
common/hpdmc_pkg.sv
datactl/hpdmc_banktimer.sv
datactl/hpdmc_datactl.sv
mgmt/hpdmc_mgmt.sv
logic/hpdmc_ctlif.sv
logic/hpdmc.sv
test/tb_hpdmc.sv
